/* verilog/ahb_mem_defs.svh */
/*
 * AHB memory model parameters
 * Bus width, storage size, interrupt lines and the register address map
 */

`ifndef AHB_MEM_DEFS_SVH
`define AHB_MEM_DEFS_SVH

// ----------------------------------------
// Sizes
// ----------------------------------------
`define AHB_WIDTH           32
// Storage is 2**MEM_POWER_SIZE bytes
`define MEM_POWER_SIZE      16
`define IRQ_LINES_NUM       16

// ----------------------------------------
// Address map
// ----------------------------------------
`define MEM_ERR_ADDR        32'hFFFFF100
`define MEM_ERR_PTR_ADDR    32'hF0000200
`define IRQ_ADDR            32'hF0000100

`endif

/* verilog/ahb_pkg.sv */
/*
 * AHB-Lite protocol types
 * Transfer, size and response encodings plus the port FSM states
 */

package ahb_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // Only the sizes up to one bus word
    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_DATA = 1'b1
    } port_state_e;

endpackage

/* verilog/mem_pkg.sv */
/*
 * Storage types for the AHB memory model
 * Word, byte-enable, address and interrupt types, and byte-enable forming
 */

`include "ahb_mem_defs.svh"

package mem_pkg;

    typedef logic [`AHB_WIDTH-1:0]      word_t;
    typedef logic [3:0]                 byte_en_t;
    typedef logic [`MEM_POWER_SIZE-1:0] mem_addr_t;
    typedef logic [`IRQ_LINES_NUM-1:0]  irq_t;

    // Lane enables from byte offset and transfer size
    function automatic byte_en_t be_form(
        input logic [1:0]      offset,
        input ahb_pkg::hsize_e hsize
    );
        case (hsize)
            ahb_pkg::HSIZE_BYTE: return byte_en_t'(4'b0001 << offset);
            ahb_pkg::HSIZE_HALF: return byte_en_t'(4'b0011 << offset);
            ahb_pkg::HSIZE_WORD: return 4'b1111;
            // Larger sizes touch no lane
            default:             return 4'b0000;
        endcase
    endfunction

endpackage

/* verilog/mem_port_if.sv */
/*
 * Storage access interfaces
 * Read and write ports between the AHB port controllers and the array
 */

interface mem_rd_if;
    import mem_pkg::*;

    logic      en;
    mem_addr_t addr;
    byte_en_t  be;
    // Combinational from the array
    word_t     rdata;

    modport ctrl (
        output en, addr, be,
        input  rdata
    );

    modport mem (
        input  en, addr, be,
        output rdata
    );
endinterface

interface mem_wr_if;
    import mem_pkg::*;

    // Committed at the clock edge while en is high
    logic      en;
    mem_addr_t addr;
    byte_en_t  be;
    word_t     wdata;

    modport ctrl (
        output en, addr, be, wdata
    );

    modport mem (
        input  en, addr, be, wdata
    );
endinterface

/* verilog/ahb_wait_gen.sv */
/*
 * Wait-state generator
 * Rotates a stall pattern and gives the port its ready level
 */

`include "ahb_mem_defs.svh"

module ahb_wait_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  mem_pkg::word_t stall_pattern,
    output logic           ready
);
    import mem_pkg::*;

    word_t pattern_q;

    // Pattern is loaded while in reset, rotated right afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pattern_q <= stall_pattern;
        end else begin
            pattern_q <= {pattern_q[0], pattern_q[`AHB_WIDTH-1:1]};
        end
    end

    // Empty pattern means no wait states at all
    assign ready = (pattern_q == '0) || pattern_q[0];

endmodule

/* verilog/ahb_mem_array.sv */
/*
 * Shared byte storage
 * One write port and two read ports, with write data forwarded into reads
 */

`include "ahb_mem_defs.svh"

module ahb_mem_array (
    input logic   clk,
    mem_rd_if.mem imem_rd,
    mem_rd_if.mem dmem_rd,
    mem_wr_if.mem wr
);
    import mem_pkg::*;

    localparam int MEM_BYTES = 2 ** `MEM_POWER_SIZE;

    // Little-endian bytes
    logic [7:0] storage [MEM_BYTES];

    // ----------------------------------------
    // Read with forwarding
    // ----------------------------------------
    function automatic word_t read_word(input mem_addr_t addr, input byte_en_t be);
        logic  hit;
        word_t data;
        hit  = wr.en && (addr[`MEM_POWER_SIZE-1:2] == wr.addr[`MEM_POWER_SIZE-1:2]);
        data = '0;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                // Byte being written this cycle wins
                if (hit && wr.be[i]) begin
                    data[8*i +: 8] = wr.wdata[8*i +: 8];
                end else begin
                    data[8*i +: 8] = storage[{addr[`MEM_POWER_SIZE-1:2], 2'(i)}];
                end
            end
        end
        return data;
    endfunction

    // Also follows the storage and the write port used inside read_word
    always_comb begin
        imem_rd.rdata = imem_rd.en ? read_word(imem_rd.addr, imem_rd.be) : '0;
        dmem_rd.rdata = dmem_rd.en ? read_word(dmem_rd.addr, dmem_rd.be) : '0;
    end

    // ----------------------------------------
    // Write
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr.be[i]) begin
                    storage[{wr.addr[`MEM_POWER_SIZE-1:2], 2'(i)}] <= wr.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* verilog/ahb_imem_port.sv */
/*
 * Instruction port
 * Read-only AHB-Lite slave FSM in front of the shared storage
 */

`include "ahb_mem_defs.svh"

module ahb_imem_port (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ready,
    input  ahb_pkg::htrans_e htrans,
    input  ahb_pkg::hsize_e  hsize,
    input  mem_pkg::word_t   haddr,
    output logic             hready,
    output mem_pkg::word_t   hrdata,
    output ahb_pkg::hresp_e  hresp,
    input  mem_pkg::word_t   err_ptr,
    mem_rd_if.ctrl           rd
);
    import ahb_pkg::*;
    import mem_pkg::*;

    port_state_e state;
    logic        accept;
    logic        addr_err;
    logic        err_q;
    word_t       rdata_q;

    // Address phase accepted; BUSY and SEQ are treated as IDLE
    assign accept   = ready && (htrans == HTRANS_NONSEQ);
    assign addr_err = (haddr == `MEM_ERR_ADDR) || (haddr == err_ptr);

    // Fetches always start at lane zero
    assign rd.en   = accept;
    assign rd.addr = haddr[`MEM_POWER_SIZE-1:0];
    assign rd.be   = be_form(2'b00, hsize);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end else begin
            if (ready) begin
                state <= accept ? ST_DATA : ST_IDLE;
            end
            if (accept) begin
                err_q <= addr_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= addr_err ? '0 : rd.rdata;
        end
    end

    // Response
    assign hready = ready;
    assign hresp  = (state == ST_DATA && ready && err_q) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata = (state == ST_DATA) ? rdata_q : '0;

endmodule

/* verilog/ahb_dmem_port.sv */
/*
 * Data port
 * Read/write AHB-Lite slave FSM with the error-pointer and interrupt registers
 */

`include "ahb_mem_defs.svh"

module ahb_dmem_port (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ready,
    input  ahb_pkg::htrans_e htrans,
    input  ahb_pkg::hsize_e  hsize,
    input  mem_pkg::word_t   haddr,
    input  logic             hwrite,
    input  mem_pkg::word_t   hwdata,
    output logic             hready,
    output mem_pkg::word_t   hrdata,
    output ahb_pkg::hresp_e  hresp,
    output mem_pkg::word_t   err_ptr,
    output mem_pkg::irq_t    irq_lines,
    mem_rd_if.ctrl           rd,
    mem_wr_if.ctrl           wr
);
    import ahb_pkg::*;
    import mem_pkg::*;

    port_state_e state;
    logic        accept;
    logic        commit;
    logic        irq_wr;
    logic        ptr_wr;
    logic        addr_err;
    byte_en_t    be;
    irq_t        irq_fwd;
    word_t       ptr_fwd;
    word_t       rd_sel;

    // Latched at acceptance
    logic        wr_q;
    logic        err_q;
    word_t       addr_q;
    byte_en_t    be_q;
    word_t       rdata_q;

    assign accept = ready && (htrans == HTRANS_NONSEQ);
    assign be     = be_form(haddr[1:0], hsize);

    // ----------------------------------------
    // Data-phase write commit
    // ----------------------------------------
    assign commit = (state == ST_DATA) && ready && wr_q && !err_q;
    assign irq_wr = commit && (addr_q == `IRQ_ADDR);
    assign ptr_wr = commit && (addr_q == `MEM_ERR_PTR_ADDR);

    // Register values including a write landing this cycle
    assign irq_fwd = irq_wr ? hwdata[`IRQ_LINES_NUM-1:0] : irq_lines;
    assign ptr_fwd = ptr_wr ? hwdata : err_ptr;

    assign addr_err = (haddr == `MEM_ERR_ADDR) || (haddr == ptr_fwd);

    // Register addresses never reach the storage
    assign wr.en    = commit && !irq_wr && !ptr_wr;
    assign wr.addr  = addr_q[`MEM_POWER_SIZE-1:0];
    assign wr.be    = be_q;
    assign wr.wdata = hwdata;

    // ----------------------------------------
    // Address-phase read
    // ----------------------------------------
    assign rd.en   = accept && !hwrite;
    assign rd.addr = haddr[`MEM_POWER_SIZE-1:0];
    assign rd.be   = be;

    always_comb begin
        if (addr_err) begin
            rd_sel = '0;
        end else if (haddr == `IRQ_ADDR) begin
            rd_sel = word_t'(irq_fwd);
        end else if (haddr == `MEM_ERR_PTR_ADDR) begin
            rd_sel = ptr_fwd;
        end else begin
            rd_sel = rd.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            wr_q      <= 1'b0;
            err_q     <= 1'b0;
            irq_lines <= '0;
            err_ptr   <= `MEM_ERR_ADDR;
        end else begin
            irq_lines <= irq_fwd;
            err_ptr   <= ptr_fwd;
            if (ready) begin
                state <= accept ? ST_DATA : ST_IDLE;
            end
            if (accept) begin
                wr_q  <= hwrite;
                err_q <= addr_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= haddr;
            be_q    <= be;
            rdata_q <= rd_sel;
        end
    end

    // Response
    assign hready = ready;
    assign hresp  = (state == ST_DATA && ready && err_q) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata = (state == ST_DATA && !wr_q) ? rdata_q : '0;

endmodule

/* verilog/ahb_mem_top.sv */
/*
 * Dual-port AHB-Lite memory model
 * Instruction and data ports sharing one byte array, each with wait states
 */

module ahb_mem_top (
    input  logic             clk,
    input  logic             rst_n,
    input  mem_pkg::word_t   imem_stall_pattern,
    input  mem_pkg::word_t   dmem_stall_pattern,

    // Instruction port
    input  ahb_pkg::htrans_e imem_htrans,
    input  ahb_pkg::hsize_e  imem_hsize,
    input  mem_pkg::word_t   imem_haddr,
    output logic             imem_hready,
    output mem_pkg::word_t   imem_hrdata,
    output ahb_pkg::hresp_e  imem_hresp,

    // Data port
    input  ahb_pkg::htrans_e dmem_htrans,
    input  ahb_pkg::hsize_e  dmem_hsize,
    input  mem_pkg::word_t   dmem_haddr,
    input  logic             dmem_hwrite,
    input  mem_pkg::word_t   dmem_hwdata,
    output logic             dmem_hready,
    output mem_pkg::word_t   dmem_hrdata,
    output ahb_pkg::hresp_e  dmem_hresp,

    output mem_pkg::irq_t    irq_lines
);
    import mem_pkg::*;

    logic  imem_ready;
    logic  dmem_ready;
    // Owned by the data port, checked by both
    word_t err_ptr;

    mem_rd_if imem_rd ();
    mem_rd_if dmem_rd ();
    mem_wr_if dmem_wr ();

    // ----------------------------------------
    // Wait states
    // ----------------------------------------
    ahb_wait_gen imem_wait_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_pattern (imem_stall_pattern),
        .ready         (imem_ready)
    );

    ahb_wait_gen dmem_wait_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_pattern (dmem_stall_pattern),
        .ready         (dmem_ready)
    );

    // ----------------------------------------
    // Ports and storage
    // ----------------------------------------
    ahb_imem_port imem_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ready   (imem_ready),
        .htrans  (imem_htrans),
        .hsize   (imem_hsize),
        .haddr   (imem_haddr),
        .hready  (imem_hready),
        .hrdata  (imem_hrdata),
        .hresp   (imem_hresp),
        .err_ptr (err_ptr),
        .rd      (imem_rd)
    );

    ahb_dmem_port dmem_port_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready     (dmem_ready),
        .htrans    (dmem_htrans),
        .hsize     (dmem_hsize),
        .haddr     (dmem_haddr),
        .hwrite    (dmem_hwrite),
        .hwdata    (dmem_hwdata),
        .hready    (dmem_hready),
        .hrdata    (dmem_hrdata),
        .hresp     (dmem_hresp),
        .err_ptr   (err_ptr),
        .irq_lines (irq_lines),
        .rd        (dmem_rd),
        .wr        (dmem_wr)
    );

    ahb_mem_array array_i (
        .clk     (clk),
        .imem_rd (imem_rd),
        .dmem_rd (dmem_rd),
        .wr      (dmem_wr)
    );

endmodule

/* tb/ahb_mem_tb.sv */
/*
 * Testbench for the dual-port AHB-Lite memory model
 * Directed tests checked against a byte-level reference model
 */

`include "ahb_mem_defs.svh"

module ahb_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ahb_pkg::*;
    import mem_pkg::*;

    localparam int    TIMEOUT_CYCLES = 100;
    localparam int    WORD_CNT       = 16;
    localparam word_t ERR_PTR_A      = 32'h0001_0040;
    localparam word_t ERR_PTR_B      = 32'hC000_0800;
    localparam word_t IMEM_PATTERN   = 32'hB6D5_A3C9;
    localparam word_t DMEM_PATTERN   = 32'h9C3A_5E17;

    logic    clk;
    logic    rst_n;
    word_t   imem_stall_pattern, dmem_stall_pattern;
    htrans_e imem_htrans, dmem_htrans;
    hsize_e  imem_hsize, dmem_hsize;
    word_t   imem_haddr, dmem_haddr;
    logic    dmem_hwrite;
    word_t   dmem_hwdata;
    logic    imem_hready, dmem_hready;
    word_t   imem_hrdata, dmem_hrdata;
    hresp_e  imem_hresp, dmem_hresp;
    irq_t    irq_lines;

    // Reference copy of the storage
    logic [7:0] ref_mem [0:(2**`MEM_POWER_SIZE)-1];
    int         errors;
    int         timeouts;
    string      cur_test;

    ahb_mem_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic byte_en_t lane_mask(input logic [1:0] offset, input hsize_e size);
        byte_en_t m;
        case (size)
            HSIZE_BYTE: m = 4'b0001;
            HSIZE_HALF: m = 4'b0011;
            default:    m = 4'b1111;
        endcase
        if (size != HSIZE_WORD) begin
            m = m << offset;
        end
        return m;
    endfunction

    function automatic void model_write(input word_t addr, input hsize_e size, input word_t data);
        byte_en_t mask;
        mask = lane_mask(addr[1:0], size);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                ref_mem[{addr[`MEM_POWER_SIZE-1:2], 2'(i)}] = data[8*i +: 8];
            end
        end
    endfunction

    // Disabled lanes read as zero
    function automatic word_t model_read(input word_t addr, input hsize_e size);
        byte_en_t mask;
        word_t    data;
        mask = lane_mask(addr[1:0], size);
        data = '0;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                data[8*i +: 8] = ref_mem[{addr[`MEM_POWER_SIZE-1:2], 2'(i)}];
            end
        end
        return data;
    endfunction

    function automatic word_t random_addr();
        return word_t'($urandom & 32'h0000_FFFC);
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_word(input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input hresp_e exp, input hresp_e act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %s, actual %s", cur_test, exp.name(), act.name());
            errors++;
        end
    endtask

    // ----------------------------------------
    // Bus helpers
    // ----------------------------------------
    task automatic wait_imem_ready(input string phase);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (imem_hready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (imem_hready !== 1'b1) begin
            $display("%s: imem hready stayed low through the %s phase", cur_test, phase);
            timeouts++;
        end
    endtask

    task automatic wait_dmem_ready(input string phase);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (dmem_hready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (dmem_hready !== 1'b1) begin
            $display("%s: dmem hready stayed low through the %s phase", cur_test, phase);
            timeouts++;
        end
    endtask

    task automatic imem_read(input word_t addr, output word_t rdata, output hresp_e resp);
        @(posedge clk);
        imem_htrans <= HTRANS_NONSEQ;
        imem_haddr  <= addr;
        imem_hsize  <= HSIZE_WORD;
        wait_imem_ready("address");
        @(posedge clk);
        imem_htrans <= HTRANS_IDLE;
        wait_imem_ready("data");
        rdata = imem_hrdata;
        resp  = imem_hresp;
    endtask

    // Returns at the last cycle of the data phase
    task automatic dmem_access(input word_t addr, input hsize_e size, input logic write,
                               input word_t wdata, output word_t rdata, output hresp_e resp);
        @(posedge clk);
        dmem_htrans <= HTRANS_NONSEQ;
        dmem_haddr  <= addr;
        dmem_hsize  <= size;
        dmem_hwrite <= write;
        wait_dmem_ready("address");
        @(posedge clk);
        dmem_htrans <= HTRANS_IDLE;
        dmem_hwdata <= wdata;
        wait_dmem_ready("data");
        rdata = dmem_hrdata;
        resp  = dmem_hresp;
    endtask

    task automatic dmem_read(input word_t addr, input hsize_e size,
                             output word_t rdata, output hresp_e resp);
        dmem_access(addr, size, 1'b0, '0, rdata, resp);
    endtask

    task automatic dmem_write(input word_t addr, input hsize_e size, input word_t data,
                              output hresp_e resp);
        word_t unused;
        dmem_access(addr, size, 1'b1, data, unused, resp);
    endtask

    task automatic dmem_write_ok(input word_t addr, input hsize_e size, input word_t data);
        hresp_e resp;
        dmem_write(addr, size, data, resp);
        model_write(addr, size, data);
        check_resp(HRESP_OKAY, resp);
    endtask

    task automatic dmem_read_check(input word_t addr, input hsize_e size);
        word_t  rdata;
        hresp_e resp;
        dmem_read(addr, size, rdata, resp);
        check_word(model_read(addr, size), rdata);
        check_resp(HRESP_OKAY, resp);
    endtask

    task automatic imem_read_check(input word_t addr);
        word_t  rdata;
        hresp_e resp;
        imem_read(addr, rdata, resp);
        check_word(model_read(addr, HSIZE_WORD), rdata);
        check_resp(HRESP_OKAY, resp);
    endtask

    // Patterns are loaded while reset is low
    task automatic reset_dut(input word_t imem_pat, input word_t dmem_pat);
        @(posedge clk);
        rst_n              <= 1'b0;
        imem_stall_pattern <= imem_pat;
        dmem_stall_pattern <= dmem_pat;
        imem_htrans        <= HTRANS_IDLE;
        dmem_htrans        <= HTRANS_IDLE;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_word_rw();
        word_t addr [WORD_CNT];
        cur_test = "word_rw";
        for (int i = 0; i < WORD_CNT; i++) begin
            addr[i] = random_addr();
            dmem_write_ok(addr[i], HSIZE_WORD, $urandom);
        end
        for (int i = 0; i < WORD_CNT; i++) begin
            dmem_read_check(addr[i], HSIZE_WORD);
            imem_read_check(addr[i]);
        end
    endtask

    task automatic test_sub_word();
        word_t base;
        word_t addr;
        cur_test = "sub_word";
        base = random_addr();
        dmem_write_ok(base, HSIZE_WORD, $urandom);
        for (int off = 0; off < 4; off++) begin
            addr = base + word_t'(off);
            dmem_write_ok(addr, HSIZE_BYTE, $urandom);
            dmem_read_check(addr, HSIZE_BYTE);
            dmem_read_check(base + word_t'(off & 2), HSIZE_HALF);
            dmem_read_check(base, HSIZE_WORD);
        end
        for (int off = 0; off < 4; off += 2) begin
            addr = base + word_t'(off);
            dmem_write_ok(addr, HSIZE_HALF, $urandom);
            dmem_read_check(addr, HSIZE_HALF);
            dmem_read_check(base, HSIZE_WORD);
        end
    endtask

    // With zero patterns each phase takes exactly one cycle
    task automatic test_forwarding();
        word_t addr;
        word_t data;
        cur_test = "forwarding";
        addr = random_addr();
        data = $urandom;
        dmem_write_ok(addr, HSIZE_WORD, $urandom);
        @(posedge clk);
        dmem_htrans <= HTRANS_NONSEQ;
        dmem_haddr  <= addr + 32'd2;
        dmem_hsize  <= HSIZE_HALF;
        dmem_hwrite <= 1'b1;
        wait_dmem_ready("address");
        // imem address phase overlaps the dmem write data phase
        @(posedge clk);
        dmem_htrans <= HTRANS_IDLE;
        dmem_hwdata <= data;
        imem_htrans <= HTRANS_NONSEQ;
        imem_haddr  <= addr;
        imem_hsize  <= HSIZE_WORD;
        wait_dmem_ready("data");
        model_write(addr + 32'd2, HSIZE_HALF, data);
        @(posedge clk);
        imem_htrans <= HTRANS_IDLE;
        wait_imem_ready("data");
        check_word(model_read(addr, HSIZE_WORD), imem_hrdata);
        check_resp(HRESP_OKAY, imem_hresp);
    endtask

    task automatic test_error_resp();
        word_t  rdata;
        hresp_e resp;
        cur_test = "error_resp";
        dmem_read(`MEM_ERR_ADDR, HSIZE_WORD, rdata, resp);
        check_resp(HRESP_ERROR, resp);
        check_word('0, rdata);
        imem_read(`MEM_ERR_ADDR, rdata, resp);
        check_resp(HRESP_ERROR, resp);
        check_word('0, rdata);
        dmem_write_ok(ERR_PTR_A, HSIZE_WORD, $urandom);
        dmem_write(`MEM_ERR_PTR_ADDR, HSIZE_WORD, ERR_PTR_A, resp);
        check_resp(HRESP_OKAY, resp);
        // This write must be dropped
        dmem_write(ERR_PTR_A, HSIZE_WORD, $urandom, resp);
        check_resp(HRESP_ERROR, resp);
        imem_read(ERR_PTR_A, rdata, resp);
        check_resp(HRESP_ERROR, resp);
        check_word('0, rdata);
        dmem_write(`MEM_ERR_PTR_ADDR, HSIZE_WORD, ERR_PTR_B, resp);
        check_resp(HRESP_OKAY, resp);
        dmem_read(`MEM_ERR_PTR_ADDR, HSIZE_WORD, rdata, resp);
        check_word(ERR_PTR_B, rdata);
        check_resp(HRESP_OKAY, resp);
        dmem_read_check(ERR_PTR_A, HSIZE_WORD);
        imem_read_check(ERR_PTR_A);
        dmem_read(ERR_PTR_B, HSIZE_WORD, rdata, resp);
        check_resp(HRESP_ERROR, resp);
        check_word('0, rdata);
        dmem_read(`MEM_ERR_ADDR, HSIZE_WORD, rdata, resp);
        check_resp(HRESP_ERROR, resp);
    endtask

    task automatic test_irq_reg();
        word_t  data;
        word_t  rdata;
        hresp_e resp;
        cur_test = "irq_reg";
        data = $urandom;
        dmem_write(`IRQ_ADDR, HSIZE_WORD, data, resp);
        check_resp(HRESP_OKAY, resp);
        @(posedge clk);
        @(negedge clk);
        check_word(word_t'(data[`IRQ_LINES_NUM-1:0]), word_t'(irq_lines));
        dmem_read(`IRQ_ADDR, HSIZE_WORD, rdata, resp);
        check_word(word_t'(data[`IRQ_LINES_NUM-1:0]), rdata);
        check_resp(HRESP_OKAY, resp);
    endtask

    task automatic test_wait_states();
        word_t ipat;
        word_t dpat;
        word_t addr;
        cur_test = "wait_states";
        ipat = IMEM_PATTERN;
        dpat = DMEM_PATTERN;
        reset_dut(ipat, dpat);
        for (int c = 0; c < 40; c++) begin
            @(negedge clk);
            if (c == 0) begin
                check_word('0, word_t'(irq_lines));
            end
            check_word(word_t'(ipat[0]), word_t'(imem_hready));
            check_word(word_t'(dpat[0]), word_t'(dmem_hready));
            ipat = {ipat[0], ipat[`AHB_WIDTH-1:1]};
            dpat = {dpat[0], dpat[`AHB_WIDTH-1:1]};
        end
        for (int i = 0; i < 8; i++) begin
            addr = random_addr();
            dmem_write_ok(addr, HSIZE_WORD, $urandom);
            dmem_read_check(addr, HSIZE_WORD);
            imem_read_check(addr);
        end
    endtask

    initial begin
        void'($urandom(32'h7100));
        errors             = 0;
        timeouts           = 0;
        rst_n              = 1'b0;
        imem_stall_pattern = '0;
        dmem_stall_pattern = '0;
        imem_htrans        = HTRANS_IDLE;
        imem_hsize         = HSIZE_WORD;
        imem_haddr         = '0;
        dmem_htrans        = HTRANS_IDLE;
        dmem_hsize         = HSIZE_WORD;
        dmem_haddr         = '0;
        dmem_hwrite        = 1'b0;
        dmem_hwdata        = '0;
        reset_dut('0, '0);
        test_word_rw();
        test_sub_word();
        test_forwarding();
        test_error_resp();
        test_irq_reg();
        test_wait_states();
        $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/ahb_pkg.sv
verilog/mem_pkg.sv
verilog/mem_port_if.sv
verilog/ahb_wait_gen.sv
verilog/ahb_mem_array.sv
verilog/ahb_imem_port.sv
verilog/ahb_dmem_port.sv
verilog/ahb_mem_top.sv
tb/ahb_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AHB memory model testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module ahb_mem_tb -o ahb_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ahb_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
